// ==== rtl/ccu_pkg.sv ====
package ccu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned PORT_ID_W   = 4;
  localparam int unsigned NUM_PORTS   = 2;
  localparam int unsigned LINE_BASE   = 4;
  localparam int unsigned LINE_W      = 8;
  localparam int unsigned TRACK_DEPTH = 8;

  // Class mux prepends the port index, final mux the path bit
  localparam int unsigned MUX_ID_W = PORT_ID_W + 1;
  localparam int unsigned MEM_ID_W = MUX_ID_W + 1;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [PORT_ID_W-1:0] port_id_t;
  typedef logic [MUX_ID_W-1:0]  mux_id_t;
  typedef logic [MEM_ID_W-1:0]  mem_id_t;
  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [1:0]           domain_t;

  // Shareable domains that take the snooping path
  localparam domain_t DOM_INNER = 2'b01;
  localparam domain_t DOM_OUTER = 2'b10;

  ////////////////////
  // Channels
  ////////////////////

  typedef struct packed {
    port_id_t id;
    addr_t    addr;
    domain_t  domain;
  } port_ar_t;

  typedef struct packed {
    port_id_t id;
    data_t    data;
  } port_r_t;

  typedef struct packed {
    logic     ar_valid;
    port_ar_t ar;
    logic     r_ready;
    logic     rack;
  } port_req_t;

  typedef struct packed {
    logic    ar_ready;
    logic    r_valid;
    port_r_t r;
  } port_resp_t;

  typedef struct packed {
    mem_id_t id;
    addr_t   addr;
  } mem_ar_t;

  typedef struct packed {
    mem_id_t id;
    data_t   data;
  } mem_r_t;

  typedef enum logic [1:0] {
    ENTRY_FREE,
    ENTRY_PENDING,
    ENTRY_DONE
  } entry_state_e;

endpackage

// ==== rtl/ccu_port_demux.sv ====
`timescale 1ns/100ps

module ccu_port_demux import ccu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  port_req_t  req_i,
  output port_resp_t resp_o,
  output port_ar_t   snp_ar_o,
  output logic       snp_ar_valid_o,
  input  logic       snp_ar_ready_i,
  output port_ar_t   nsn_ar_o,
  output logic       nsn_ar_valid_o,
  input  logic       nsn_ar_ready_i,
  input  port_r_t    snp_r_i,
  input  logic       snp_r_valid_i,
  output logic       snp_r_ready_o,
  input  port_r_t    nsn_r_i,
  input  logic       nsn_r_valid_i,
  output logic       nsn_r_ready_o,
  output logic       snp_rack_o
);

  port_ar_t   ar_q;
  logic       ar_valid_q;
  logic       ar_snp_q;
  logic       ar_snp;
  logic       ar_out_ready;
  logic       r_hold_q;
  logic       r_hold_snp_q;
  logic       r_sel_snp;
  logic       r_push;
  logic [1:0] ord_q;
  logic [1:0] ord_cnt_q;
  logic       ord_full;

  ////////////////////
  // AR spill
  ////////////////////

  assign ar_snp = (req_i.ar.domain == DOM_INNER) || (req_i.ar.domain == DOM_OUTER);
  assign ar_out_ready = ar_snp_q ? snp_ar_ready_i : nsn_ar_ready_i;
  assign resp_o.ar_ready = !ar_valid_q || ar_out_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ar_valid_q <= 1'b0;
    end else if (resp_o.ar_ready) begin
      ar_valid_q <= req_i.ar_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.ar_valid && resp_o.ar_ready) begin
      ar_q     <= req_i.ar;
      ar_snp_q <= ar_snp;
    end
  end

  assign snp_ar_o       = ar_q;
  assign nsn_ar_o       = ar_q;
  assign snp_ar_valid_o = ar_valid_q && ar_snp_q;
  assign nsn_ar_valid_o = ar_valid_q && !ar_snp_q;

  ////////////////////
  // R merge
  ////////////////////

  // Keep the presented path until the port takes it
  assign r_sel_snp = r_hold_q ? r_hold_snp_q : snp_r_valid_i;
  assign ord_full  = (ord_cnt_q == 2'd2);

  assign resp_o.r_valid = (snp_r_valid_i || nsn_r_valid_i) && !ord_full;
  assign resp_o.r       = r_sel_snp ? snp_r_i : nsn_r_i;
  assign snp_r_ready_o  = req_i.r_ready && !ord_full && r_sel_snp;
  assign nsn_r_ready_o  = req_i.r_ready && !ord_full && !r_sel_snp;
  assign r_push         = resp_o.r_valid && req_i.r_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_hold_q <= 1'b0;
    end else begin
      r_hold_q <= resp_o.r_valid && !req_i.r_ready;
    end
  end

  always_ff @(posedge clk_i) begin
    r_hold_snp_q <= r_sel_snp;
  end

  // Path order of completed reads, popped by rack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ord_cnt_q <= '0;
    end else begin
      ord_cnt_q <= ord_cnt_q + 2'(r_push) - 2'(req_i.rack);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.rack) begin
      if (ord_cnt_q == 2'd2) begin
        ord_q[0] <= ord_q[1];
      end else if (r_push) begin
        ord_q[0] <= r_sel_snp;
      end
    end else if (r_push) begin
      ord_q[ord_cnt_q[0]] <= r_sel_snp;
    end
  end

  assign snp_rack_o = req_i.rack && ord_q[0];

  rack_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.rack |-> ord_cnt_q != 2'd0);

endmodule

// ==== rtl/ccu_rr_mux.sv ====
`timescale 1ns/100ps

module ccu_rr_mux import ccu_pkg::*; #(
  parameter int unsigned NumIn     = 2,
  parameter int unsigned InIdWidth = 4,
  localparam int unsigned IdxW       = $clog2(NumIn),
  localparam int unsigned OutIdWidth = InIdWidth + IdxW
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic [NumIn-1:0]                 in_valid_i,
  output logic [NumIn-1:0]                 in_ready_o,
  input  logic [NumIn-1:0][InIdWidth-1:0]  in_id_i,
  input  addr_t [NumIn-1:0]                in_addr_i,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic [OutIdWidth-1:0]            out_id_o,
  output addr_t                            out_addr_o,
  input  logic                             out_r_valid_i,
  output logic                             out_r_ready_o,
  input  logic [OutIdWidth-1:0]            out_r_id_i,
  input  data_t                            out_r_data_i,
  output logic [NumIn-1:0]                 in_r_valid_o,
  input  logic [NumIn-1:0]                 in_r_ready_i,
  output logic [NumIn-1:0][InIdWidth-1:0]  in_r_id_o,
  output data_t [NumIn-1:0]                in_r_data_o
);

  logic [IdxW-1:0]  prio_q;
  logic [IdxW-1:0]  gnt_idx;
  logic [NumIn-1:0] gnt;
  logic             load;
  logic [IdxW-1:0]  r_idx;

  assign load = !out_valid_o || out_ready_i;

  // First valid input at or after the priority pointer
  always_comb begin
    int cand;
    gnt     = '0;
    gnt_idx = '0;
    for (int k = NumIn - 1; k >= 0; k--) begin
      cand = (int'(prio_q) + k) % NumIn;
      if (in_valid_i[cand] && load) begin
        gnt     = '0;
        gnt[cand] = 1'b1;
        gnt_idx = IdxW'(cand);
      end
    end
  end

  assign in_ready_o = gnt;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      prio_q      <= '0;
    end else if (load) begin
      out_valid_o <= |gnt;
      if (|gnt) begin
        prio_q <= IdxW'((int'(gnt_idx) + 1) % NumIn);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|gnt) begin
      out_id_o   <= {gnt_idx, in_id_i[gnt_idx]};
      out_addr_o <= in_addr_i[gnt_idx];
    end
  end

  ////////////////////
  // R routing
  ////////////////////

  assign r_idx = out_r_id_i[OutIdWidth-1 -: IdxW];

  always_comb begin
    for (int i = 0; i < NumIn; i++) begin
      in_r_valid_o[i] = out_r_valid_i && (int'(r_idx) == i);
      in_r_id_o[i]    = out_r_id_i[InIdWidth-1:0];
      in_r_data_o[i]  = out_r_data_i;
    end
  end

  assign out_r_ready_o = in_r_ready_i[r_idx];

  gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    (load && |in_valid_i) |-> $onehot(gnt));

endmodule

// ==== rtl/ccu_line_tracker.sv ====
`timescale 1ns/100ps

module ccu_line_tracker import ccu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  mux_id_t               ar_id_i,
  input  line_t                 ar_line_i,
  input  logic                  r_valid_i,
  input  logic                  r_ready_i,
  input  mux_id_t               r_id_i,
  output logic                  r_valid_o,
  output logic                  r_ready_o,
  input  logic [NUM_PORTS-1:0]  rack_i,
  output logic [NUM_PORTS-1:0]  cm_req_o,
  output line_t [NUM_PORTS-1:0] cm_addr_o
);

  localparam int unsigned IDX_W = $clog2(TRACK_DEPTH);

  entry_state_e             state_q [TRACK_DEPTH];
  mux_id_t                  ent_id_q [TRACK_DEPTH];
  line_t                    ent_line_q [TRACK_DEPTH];
  logic [IDX_W-1:0]         alloc_idx;
  logic [TRACK_DEPTH-1:0]   id_busy;
  logic [TRACK_DEPTH-1:0]   r_hit;
  logic [TRACK_DEPTH-1:0]   rel;
  line_t [NUM_PORTS-1:0]    rel_line;
  logic                     ar_fire;
  logic                     r_block;
  logic                     r_fire;
  logic [NUM_PORTS-1:0]     dq_push;
  mux_id_t                  dq_q [NUM_PORTS][2];
  logic [1:0]               dq_cnt_q [NUM_PORTS];

  ////////////////////
  // Entry lookup
  ////////////////////

  always_comb begin
    ar_ready_o = 1'b0;
    alloc_idx  = '0;
    for (int e = TRACK_DEPTH - 1; e >= 0; e--) begin
      if (state_q[e] == ENTRY_FREE) begin
        ar_ready_o = 1'b1;
        alloc_idx  = IDX_W'(e);
      end
      id_busy[e] = (state_q[e] != ENTRY_FREE) && (ent_id_q[e] == ar_id_i);
      r_hit[e]   = (state_q[e] == ENTRY_PENDING) && (ent_id_q[e] == r_id_i);
    end
  end

  // Rack releases the done entry at the head of that port's queue
  always_comb begin
    rel = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rel_line[p] = '0;
      for (int e = 0; e < TRACK_DEPTH; e++) begin
        if (rack_i[p] && state_q[e] == ENTRY_DONE && ent_id_q[e] == dq_q[p][0]) begin
          rel[e]      = 1'b1;
          rel_line[p] = ent_line_q[e];
        end
      end
    end
  end

  assign ar_fire   = ar_valid_i && ar_ready_o;
  assign r_block   = (dq_cnt_q[r_id_i[MUX_ID_W-1]] == 2'd2);
  assign r_valid_o = r_valid_i && !r_block;
  assign r_ready_o = r_ready_i && !r_block;
  assign r_fire    = r_valid_i && r_ready_i && !r_block;
  assign dq_push   = r_fire ? (NUM_PORTS'(1) << r_id_i[MUX_ID_W-1]) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int e = 0; e < TRACK_DEPTH; e++) begin
        state_q[e] <= ENTRY_FREE;
      end
    end else begin
      for (int e = 0; e < TRACK_DEPTH; e++) begin
        if (ar_fire && alloc_idx == IDX_W'(e)) begin
          state_q[e] <= ENTRY_PENDING;
        end else if (r_fire && r_hit[e]) begin
          state_q[e] <= ENTRY_DONE;
        end else if (rel[e]) begin
          state_q[e] <= ENTRY_FREE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      ent_id_q[alloc_idx]   <= ar_id_i;
      ent_line_q[alloc_idx] <= ar_line_i;
    end
  end

  ////////////////////
  // Done queues
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        dq_cnt_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        dq_cnt_q[p] <= dq_cnt_q[p] + 2'(dq_push[p]) - 2'(rack_i[p]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rack_i[p]) begin
        if (dq_cnt_q[p] == 2'd2) begin
          dq_q[p][0] <= dq_q[p][1];
        end else if (dq_push[p]) begin
          dq_q[p][0] <= r_id_i;
        end
      end else if (dq_push[p]) begin
        dq_q[p][dq_cnt_q[p][0]] <= r_id_i;
      end
    end
  end

  // Coherence monitor, one cycle after rack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cm_req_o <= '0;
    end else begin
      cm_req_o <= rack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rack_i[p]) begin
        cm_addr_o[p] <= rel_line[p];
      end
    end
  end

  id_unique: assert property (@(posedge clk_i) disable iff (rst_i)
    ar_fire |-> !(|id_busy));

endmodule

// ==== rtl/ccu_master_path.sv ====
`timescale 1ns/100ps

module ccu_master_path import ccu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  port_req_t [NUM_PORTS-1:0]  port_req_i,
  output port_resp_t [NUM_PORTS-1:0] port_resp_o,
  output mem_ar_t                    mem_ar_o,
  output logic                       mem_ar_valid_o,
  input  logic                       mem_ar_ready_i,
  input  mem_r_t                     mem_r_i,
  input  logic                       mem_r_valid_i,
  output logic                       mem_r_ready_o,
  output logic [NUM_PORTS-1:0]       cm_req_o,
  output line_t [NUM_PORTS-1:0]      cm_addr_o
);

  port_ar_t [NUM_PORTS-1:0] snp_ar, nsn_ar;
  port_r_t  [NUM_PORTS-1:0] snp_r, nsn_r;
  logic     [NUM_PORTS-1:0] snp_ar_valid, snp_ar_ready, nsn_ar_valid, nsn_ar_ready;
  logic     [NUM_PORTS-1:0] snp_r_valid, snp_r_ready, nsn_r_valid, nsn_r_ready;
  logic     [NUM_PORTS-1:0] snp_rack;
  port_id_t [NUM_PORTS-1:0] snp_ar_id, nsn_ar_id, snp_r_id, nsn_r_id;
  addr_t    [NUM_PORTS-1:0] snp_ar_addr, nsn_ar_addr;
  data_t    [NUM_PORTS-1:0] snp_r_data, nsn_r_data;

  // Final mux inputs: 0 non-snooping, 1 snooping
  logic    [1:0] fin_ar_valid, fin_ar_ready, fin_r_valid, fin_r_ready;
  mux_id_t [1:0] fin_ar_id, fin_r_id;
  addr_t   [1:0] fin_ar_addr;
  data_t   [1:0] fin_r_data;

  logic snp_mux_ar_valid, snp_mux_ar_ready, snp_mux_r_valid, snp_mux_r_ready;
  logic trk_ar_ready;

  ////////////////////
  // Port demux
  ////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    ccu_port_demux i_demux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_i          (port_req_i[p]),
      .resp_o         (port_resp_o[p]),
      .snp_ar_o       (snp_ar[p]),
      .snp_ar_valid_o (snp_ar_valid[p]),
      .snp_ar_ready_i (snp_ar_ready[p]),
      .nsn_ar_o       (nsn_ar[p]),
      .nsn_ar_valid_o (nsn_ar_valid[p]),
      .nsn_ar_ready_i (nsn_ar_ready[p]),
      .snp_r_i        (snp_r[p]),
      .snp_r_valid_i  (snp_r_valid[p]),
      .snp_r_ready_o  (snp_r_ready[p]),
      .nsn_r_i        (nsn_r[p]),
      .nsn_r_valid_i  (nsn_r_valid[p]),
      .nsn_r_ready_o  (nsn_r_ready[p]),
      .snp_rack_o     (snp_rack[p])
    );

    assign snp_ar_id[p]   = snp_ar[p].id;
    assign snp_ar_addr[p] = snp_ar[p].addr;
    assign nsn_ar_id[p]   = nsn_ar[p].id;
    assign nsn_ar_addr[p] = nsn_ar[p].addr;
    assign snp_r[p]       = '{id: snp_r_id[p], data: snp_r_data[p]};
    assign nsn_r[p]       = '{id: nsn_r_id[p], data: nsn_r_data[p]};
  end

  ////////////////////
  // Class muxes
  ////////////////////

  ccu_rr_mux #(
    .NumIn     (NUM_PORTS),
    .InIdWidth (PORT_ID_W)
  ) i_nosnoop_mux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (nsn_ar_valid),
    .in_ready_o    (nsn_ar_ready),
    .in_id_i       (nsn_ar_id),
    .in_addr_i     (nsn_ar_addr),
    .out_valid_o   (fin_ar_valid[0]),
    .out_ready_i   (fin_ar_ready[0]),
    .out_id_o      (fin_ar_id[0]),
    .out_addr_o    (fin_ar_addr[0]),
    .out_r_valid_i (fin_r_valid[0]),
    .out_r_ready_o (fin_r_ready[0]),
    .out_r_id_i    (fin_r_id[0]),
    .out_r_data_i  (fin_r_data[0]),
    .in_r_valid_o  (nsn_r_valid),
    .in_r_ready_i  (nsn_r_ready),
    .in_r_id_o     (nsn_r_id),
    .in_r_data_o   (nsn_r_data)
  );

  ccu_rr_mux #(
    .NumIn     (NUM_PORTS),
    .InIdWidth (PORT_ID_W)
  ) i_snoop_mux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (snp_ar_valid),
    .in_ready_o    (snp_ar_ready),
    .in_id_i       (snp_ar_id),
    .in_addr_i     (snp_ar_addr),
    .out_valid_o   (snp_mux_ar_valid),
    .out_ready_i   (snp_mux_ar_ready),
    .out_id_o      (fin_ar_id[1]),
    .out_addr_o    (fin_ar_addr[1]),
    .out_r_valid_i (snp_mux_r_valid),
    .out_r_ready_o (snp_mux_r_ready),
    .out_r_id_i    (fin_r_id[1]),
    .out_r_data_i  (fin_r_data[1]),
    .in_r_valid_o  (snp_r_valid),
    .in_r_ready_i  (snp_r_ready),
    .in_r_id_o     (snp_r_id),
    .in_r_data_o   (snp_r_data)
  );

  ////////////////////
  // Line tracking
  ////////////////////

  // Snooping AR forks to the tracker and the final mux
  assign fin_ar_valid[1]  = snp_mux_ar_valid && trk_ar_ready;
  assign snp_mux_ar_ready = fin_ar_ready[1] && trk_ar_ready;

  ccu_line_tracker i_tracker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_valid_i (snp_mux_ar_valid && fin_ar_ready[1]),
    .ar_ready_o (trk_ar_ready),
    .ar_id_i    (fin_ar_id[1]),
    .ar_line_i  (fin_ar_addr[1][LINE_BASE +: LINE_W]),
    .r_valid_i  (fin_r_valid[1]),
    .r_ready_i  (snp_mux_r_ready),
    .r_id_i     (fin_r_id[1]),
    .r_valid_o  (snp_mux_r_valid),
    .r_ready_o  (fin_r_ready[1]),
    .rack_i     (snp_rack),
    .cm_req_o   (cm_req_o),
    .cm_addr_o  (cm_addr_o)
  );

  ////////////////////
  // Final mux
  ////////////////////

  ccu_rr_mux #(
    .NumIn     (2),
    .InIdWidth (MUX_ID_W)
  ) i_mem_mux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (fin_ar_valid),
    .in_ready_o    (fin_ar_ready),
    .in_id_i       (fin_ar_id),
    .in_addr_i     (fin_ar_addr),
    .out_valid_o   (mem_ar_valid_o),
    .out_ready_i   (mem_ar_ready_i),
    .out_id_o      (mem_ar_o.id),
    .out_addr_o    (mem_ar_o.addr),
    .out_r_valid_i (mem_r_valid_i),
    .out_r_ready_o (mem_r_ready_o),
    .out_r_id_i    (mem_r_i.id),
    .out_r_data_i  (mem_r_i.data),
    .in_r_valid_o  (fin_r_valid),
    .in_r_ready_i  (fin_r_ready),
    .in_r_id_o     (fin_r_id),
    .in_r_data_o   (fin_r_data)
  );

endmodule

// ==== testbench/ccu_checker.sv ====
`timescale 1ns/100ps

module ccu_checker import ccu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  port_req_t [NUM_PORTS-1:0]  port_req_i,
  input  port_resp_t [NUM_PORTS-1:0] port_resp_i,
  input  mem_ar_t                    mem_ar_i,
  input  logic                       mem_ar_valid_i,
  input  logic                       mem_ar_ready_i,
  input  logic [NUM_PORTS-1:0]       cm_req_i,
  input  line_t [NUM_PORTS-1:0]      cm_addr_i,
  output int                         done_o,
  output int                         errors_o,
  output int                         max_snp_o
);

  // Read state per port and id is 0 idle, 1 issued, 2 at memory or 3 responded
  int    st [32];
  addr_t exp_addr [32];
  logic  snp [32];
  logic  bad [32];
  int    cq [NUM_PORTS][$];
  logic  cm_exp [NUM_PORTS];
  logic  cm_has [NUM_PORTS];
  int    cm_key [NUM_PORTS];
  int    snp_out;

  task automatic flag(int key, string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors_o++;
    if (key >= 0) begin
      bad[key] = 1'b1;
    end
  endtask

  always @(posedge clk_i) begin : watch
    int key;

    if (rst_i) begin
      for (int k = 0; k < 32; k++) begin
        st[k] = 0;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        cm_exp[p] = 1'b0;
        cm_has[p] = 1'b0;
      end
      done_o    = 0;
      errors_o  = 0;
      max_snp_o = 0;
      snp_out   = 0;
    end else begin
      ////////////////////
      // Coherence monitor
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (cm_req_i[p]) begin
          snp_out--;
        end
        if (cm_req_i[p] !== cm_exp[p]) begin
          flag(cm_has[p] ? cm_key[p] : -1, $sformatf("cm_req port %0d is %b, expected %b",
               p, cm_req_i[p], cm_exp[p]));
        end else if (cm_exp[p] && cm_addr_i[p] !== exp_addr[cm_key[p]][11:4]) begin
          flag(cm_key[p], $sformatf("cm_addr port %0d is %h, expected %h", p,
               cm_addr_i[p], exp_addr[cm_key[p]][11:4]));
        end
        if (cm_has[p]) begin
          key = cm_key[p];
          $display("read port %0d id %0d addr %h %s: %s", p, key % 16, exp_addr[key],
                   snp[key] ? "snooping" : "plain", bad[key] ? "FAILED" : "ok");
          st[key] = 0;
          done_o++;
        end
        cm_exp[p] = 1'b0;
        cm_has[p] = 1'b0;
        if (port_req_i[p].rack) begin
          if (cq[p].size() == 0) begin
            $display("Port %0d sent rack with no completed read", p);
            errors_o++;
          end else begin
            cm_key[p] = cq[p].pop_front();
            cm_has[p] = 1'b1;
            cm_exp[p] = snp[cm_key[p]];
          end
        end
      end

      // Port requests
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_req_i[p].ar_valid && port_resp_i[p].ar_ready) begin
          key = p * 16 + int'(port_req_i[p].ar.id);
          if (st[key] != 0) begin
            $display("Port %0d reused id %0d while it was outstanding", p, key % 16);
            errors_o++;
          end
          st[key]       = 1;
          exp_addr[key] = port_req_i[p].ar.addr;
          snp[key]      = port_req_i[p].ar.domain inside {2'b01, 2'b10};
          bad[key]      = 1'b0;
        end
      end

      // Memory requests
      if (mem_ar_valid_i && mem_ar_ready_i) begin
        key = int'(mem_ar_i.id[4:0]);
        if (st[key] != 1) begin
          $display("Memory saw id %h that no port has waiting", mem_ar_i.id);
          errors_o++;
        end else begin
          if (mem_ar_i.id[5] !== snp[key]) begin
            flag(key, $sformatf("path bit %b for id %h", mem_ar_i.id[5], mem_ar_i.id));
          end
          if (mem_ar_i.addr !== exp_addr[key]) begin
            flag(key, $sformatf("memory addr %h, expected %h", mem_ar_i.addr, exp_addr[key]));
          end
          st[key] = 2;
          if (snp[key]) begin
            snp_out++;
            if (snp_out > max_snp_o) begin
              max_snp_o = snp_out;
            end
            if (snp_out > TRACK_DEPTH) begin
              flag(key, $sformatf("%0d snooping reads outstanding", snp_out));
            end
          end
        end
      end

      // Port responses
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_resp_i[p].r_valid && port_req_i[p].r_ready) begin
          key = p * 16 + int'(port_resp_i[p].r.id);
          if (st[key] != 2) begin
            $display("Port %0d got a response for id %0d with no read at memory", p, key % 16);
            errors_o++;
          end else begin
            if (port_resp_i[p].r.data !== (exp_addr[key] ^ 32'h5a5a_0f0f)) begin
              flag(key, $sformatf("port %0d id %0d data %h", p, key % 16,
                   port_resp_i[p].r.data));
            end
            st[key] = 3;
            cq[p].push_back(key);
          end
        end
      end
    end
  end

endmodule

// ==== testbench/tb_ccu_master_path.sv ====
`timescale 1ns/100ps

module tb_ccu_master_path import ccu_pkg::*; ();

  localparam int NUM_ROWS   = 22;
  localparam int LATE_DELAY = 25;
  localparam int LIMIT      = NUM_ROWS * 40 + 100;
  localparam data_t DATA_KEY = 32'h5a5a_0f0f;

  logic                        clk_i = 1'b0;
  logic                        rst_i;
  port_req_t  [NUM_PORTS-1:0]  port_req;
  port_resp_t [NUM_PORTS-1:0]  port_resp;
  mem_ar_t                     mem_ar;
  logic                        mem_ar_valid;
  logic                        mem_ar_ready;
  mem_r_t                      mem_r;
  logic                        mem_r_valid;
  logic                        mem_r_ready;
  logic       [NUM_PORTS-1:0]  cm_req;
  line_t      [NUM_PORTS-1:0]  cm_addr;
  int                          done_cnt;
  int                          err_cnt;
  int                          max_snp;

  // Stimulus table
  int unsigned row_port [NUM_ROWS];
  port_id_t    row_id   [NUM_ROWS];
  addr_t       row_addr [NUM_ROWS];
  domain_t     row_dom  [NUM_ROWS];
  logic        row_late [NUM_ROWS];
  int          n_rows;

  always #2 clk_i = ~clk_i;

  ccu_master_path ccu_master_path_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .port_req_i     (port_req),
    .port_resp_o    (port_resp),
    .mem_ar_o       (mem_ar),
    .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_ready_i (mem_ar_ready),
    .mem_r_i        (mem_r),
    .mem_r_valid_i  (mem_r_valid),
    .mem_r_ready_o  (mem_r_ready),
    .cm_req_o       (cm_req),
    .cm_addr_o      (cm_addr)
  );

  ccu_checker checker_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .port_req_i     (port_req),
    .port_resp_i    (port_resp),
    .mem_ar_i       (mem_ar),
    .mem_ar_valid_i (mem_ar_valid),
    .mem_ar_ready_i (mem_ar_ready),
    .cm_req_i       (cm_req),
    .cm_addr_i      (cm_addr),
    .done_o         (done_cnt),
    .errors_o       (err_cnt),
    .max_snp_o      (max_snp)
  );

  task automatic add_row(int unsigned port, port_id_t id, addr_t addr, domain_t dom,
                         logic late);
    row_port[n_rows] = port;
    row_id[n_rows]   = id;
    row_addr[n_rows] = addr;
    row_dom[n_rows]  = dom;
    row_late[n_rows] = late;
    n_rows++;
  endtask

  ////////////////////
  // Requesters
  ////////////////////

  initial begin : requesters
    int          cycle;
    int          due;
    int          r_idx;
    int          pend_rows [NUM_PORTS][$];
    int          rack_due [NUM_PORTS][$];
    logic        late_of [NUM_PORTS][16];
    logic        ar_fire [NUM_PORTS];
    logic        r_fire [NUM_PORTS];
    port_id_t    r_id [NUM_PORTS];

    void'($urandom(32'he07ba345));
    n_rows = 0;
    // Plain and snooping reads with early rack
    add_row(0, 4'd0, 32'h0000_1230, 2'b00, 1'b0);
    add_row(0, 4'd1, 32'h0000_2a40, 2'b11, 1'b0);
    add_row(0, 4'd2, 32'h0000_3b50, 2'b01, 1'b0);
    add_row(0, 4'd3, 32'h0000_4c60, 2'b10, 1'b0);
    add_row(0, 4'd4, 32'h8000_05d0, 2'b00, 1'b0);
    // Nine snooping reads with late rack overflow the tracker
    for (int k = 0; k < 9; k++) begin
      add_row(0, port_id_t'(5 + k), 32'h1000_0100 + 32'(k) * 32'h110,
              (k % 2 == 0) ? 2'b01 : 2'b10, 1'b1);
    end
    add_row(1, 4'd0, 32'h0000_7700, 2'b00, 1'b0);
    add_row(1, 4'd1, 32'h0001_8810, 2'b01, 1'b0);
    add_row(1, 4'd2, 32'h0002_9920, 2'b10, 1'b0);
    add_row(1, 4'd3, 32'h0003_aa30, 2'b11, 1'b0);
    add_row(1, 4'd4, 32'h0004_bb40, 2'b01, 1'b0);
    add_row(1, 4'd5, 32'h0005_cc50, 2'b00, 1'b0);
    add_row(1, 4'd6, 32'h0006_dd60, 2'b10, 1'b0);
    add_row(1, 4'd7, 32'h0007_ee70, 2'b01, 1'b0);

    for (int i = 0; i < n_rows; i++) begin
      pend_rows[row_port[i]].push_back(i);
      late_of[row_port[i]][row_id[i]] = row_late[i];
    end

    port_req = '0;
    rst_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #1 rst_i = 1'b0;
    cycle = 0;

    forever begin
      @(posedge clk_i);
      for (int p = 0; p < NUM_PORTS; p++) begin
        ar_fire[p] = port_req[p].ar_valid && port_resp[p].ar_ready;
        r_fire[p]  = port_resp[p].r_valid && port_req[p].r_ready;
        r_id[p]    = port_resp[p].r.id;
      end
      #1;
      cycle++;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (ar_fire[p]) begin
          void'(pend_rows[p].pop_front());
          port_req[p].ar_valid = 1'b0;
        end
        if (!port_req[p].ar_valid && pend_rows[p].size() > 0) begin
          r_idx = pend_rows[p][0];
          port_req[p].ar_valid  = 1'b1;
          port_req[p].ar.id     = row_id[r_idx];
          port_req[p].ar.addr   = row_addr[r_idx];
          port_req[p].ar.domain = row_dom[r_idx];
        end
        // Racks go out in completion order
        if (r_fire[p]) begin
          due = cycle + (late_of[p][r_id[p]] ? LATE_DELAY : 1 + int'($urandom % 3));
          if (rack_due[p].size() > 0 && due <= rack_due[p][$]) begin
            due = rack_due[p][$] + 1;
          end
          rack_due[p].push_back(due);
        end
        port_req[p].rack = 1'b0;
        if (rack_due[p].size() > 0 && rack_due[p][0] <= cycle) begin
          void'(rack_due[p].pop_front());
          port_req[p].rack = 1'b1;
        end
        port_req[p].r_ready = ($urandom % 5) != 0;
      end
    end
  end

  ////////////////////
  // Memory
  ////////////////////

  initial begin : memory
    mem_id_t q_id [$];
    addr_t   q_addr [$];
    int      q_due [$];
    int      mcycle;
    logic    ar_fire;
    logic    r_fire;
    logic    found;

    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r        = '0;
    mcycle       = 0;
    forever begin
      @(posedge clk_i);
      ar_fire = mem_ar_valid && mem_ar_ready;
      r_fire  = mem_r_valid && mem_r_ready;
      if (ar_fire) begin
        q_id.push_back(mem_ar.id);
        q_addr.push_back(mem_ar.addr);
        q_due.push_back(mcycle + int'($urandom % 6));
      end
      #1;
      mcycle++;
      if (r_fire) begin
        mem_r_valid = 1'b0;
      end
      found = 1'b0;
      // Oldest entry that is due goes first so answers can leave out of order
      for (int k = 0; k < q_id.size(); k++) begin
        if (!mem_r_valid && !found && q_due[k] <= mcycle) begin
          mem_r.id    = q_id[k];
          mem_r.data  = q_addr[k] ^ DATA_KEY;
          mem_r_valid = 1'b1;
          found       = 1'b1;
          q_id.delete(k);
          q_addr.delete(k);
          q_due.delete(k);
        end
      end
      mem_ar_ready = ($urandom % 4) != 0;
    end
  end

  ////////////////////
  // End of run
  ////////////////////

  initial begin : run_control
    int cycles;

    cycles = 0;
    @(negedge rst_i);
    while (done_cnt < NUM_ROWS && cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    repeat (4) @(posedge clk_i);
    $display("reads checked %0d of %0d, errors %0d", done_cnt, NUM_ROWS, err_cnt);
    if (done_cnt == NUM_ROWS && err_cnt == 0 && max_snp == TRACK_DEPTH) begin
      $display("All checks passed");
    end else begin
      if (done_cnt < NUM_ROWS) begin
        $display("Timeout: only %0d reads finished after %0d cycles", done_cnt, cycles);
      end
      if (max_snp != TRACK_DEPTH) begin
        $display("Tracker never held all entries, peak was %0d", max_snp);
      end
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/ccu_pkg.sv
rtl/ccu_port_demux.sv
rtl/ccu_rr_mux.sv
rtl/ccu_line_tracker.sv
rtl/ccu_master_path.sv
testbench/ccu_checker.sv
testbench/tb_ccu_master_path.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the master path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ccu_master_path \
  -f project.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
